//--- common/rv32i_pkg.sv
package rv32i_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Fetch starts here out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [XLEN/8-1:0]     mbe_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_store = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // Store funct3 encodings
    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_width_e;

    typedef struct packed {
        alu_op_e      alu_op;
        logic         a1_is_pc;
        logic         b_is_imm;
        logic         reg_write;
        logic         mem_write;
        store_width_e store_width;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        ctrl_t    ctrl;
    } if_id_t;

    typedef struct packed {
        if_id_t dec;
        word_t  rs1_data;
        word_t  rs2_data;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        ctrl_t    ctrl;
        word_t    result;
        word_t    store_data;
        mbe_t     mbe;
    } ex_mem_t;

    // Writeback bus
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

//--- execute/execute_stage.sv
module execute_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  rv32i_pkg::if_id_t    if_id_i,
    input  rv32i_pkg::word_t     rs1_data_i,
    input  rv32i_pkg::word_t     rs2_data_i,
    input  rv32i_pkg::word_t     fwd_a_i,
    input  rv32i_pkg::word_t     fwd_b_i,
    input  logic                 fwd_a_sel_i,
    input  logic                 fwd_b_sel_i,
    output rv32i_pkg::reg_idx_t  id_ex_rs1_o,
    output rv32i_pkg::reg_idx_t  id_ex_rs2_o,
    output rv32i_pkg::ex_mem_t   ex_mem_o
);
    import rv32i_pkg::*;

    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    ctrl_t   ctrl;
    word_t   src_a;
    word_t   src_b;
    word_t   op_a;
    word_t   op_b;
    word_t   alu_res;
    mbe_t    mbe;

    // ID/EX register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
        end else begin
            id_ex_q.dec      <= if_id_i;
            id_ex_q.rs1_data <= rs1_data_i;
            id_ex_q.rs2_data <= rs2_data_i;
        end
    end

    assign ctrl        = id_ex_q.dec.ctrl;
    assign id_ex_rs1_o = id_ex_q.dec.rs1;
    assign id_ex_rs2_o = id_ex_q.dec.rs2;

    // Forwarded values win over the register file read
    assign src_a = fwd_a_sel_i ? fwd_a_i : id_ex_q.rs1_data;
    assign src_b = fwd_b_sel_i ? fwd_b_i : id_ex_q.rs2_data;

    assign op_a = ctrl.a1_is_pc ? id_ex_q.dec.pc : src_a;
    assign op_b = ctrl.b_is_imm ? id_ex_q.dec.imm : src_b;

    always_comb begin
        case (ctrl.alu_op)
            alu_add:    alu_res = op_a + op_b;
            alu_sub:    alu_res = op_a - op_b;
            alu_sll:    alu_res = op_a << op_b[4:0];
            alu_slt:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_res = {31'd0, op_a < op_b};
            alu_xor:    alu_res = op_a ^ op_b;
            alu_srl:    alu_res = op_a >> op_b[4:0];
            alu_sra:    alu_res = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:     alu_res = op_a | op_b;
            alu_and:    alu_res = op_a & op_b;
            alu_pass_b: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    // Byte lanes from store width and the low address bits
    always_comb begin
        if (!ctrl.mem_write) begin
            mbe = '0;
        end else begin
            case (ctrl.store_width)
                sb:      mbe = 4'b0001 << alu_res[1:0];
                sh:      mbe = 4'b0011 << alu_res[1:0];
                default: mbe = 4'b1111;
            endcase
        end
    end

    always_comb begin
        ex_mem_d.valid      = id_ex_q.dec.valid;
        ex_mem_d.rd         = id_ex_q.dec.rd;
        ex_mem_d.ctrl       = ctrl;
        ex_mem_d.result     = alu_res;
        ex_mem_d.store_data = src_b;
        ex_mem_d.mbe        = mbe;
    end

    // EX/MEM register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= ex_mem_d;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

//--- execute/forwarding_unit.sv
module forwarding_unit (
    input  rv32i_pkg::reg_idx_t rs1_i,
    input  rv32i_pkg::reg_idx_t rs2_i,
    input  rv32i_pkg::ex_mem_t  ex_mem_i,
    input  rv32i_pkg::wb_t      wb_i,
    output rv32i_pkg::word_t    fwd_a_o,
    output rv32i_pkg::word_t    fwd_b_o,
    output logic                fwd_a_sel_o,
    output logic                fwd_b_sel_o
);
    import rv32i_pkg::*;

    logic ex_writes;
    logic wb_writes;
    logic ex_hit_a;
    logic ex_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;

    // x0 destinations never forward
    assign ex_writes = ex_mem_i.valid && ex_mem_i.ctrl.reg_write && (ex_mem_i.rd != '0);
    assign wb_writes = wb_i.we && (wb_i.rd != '0);

    assign ex_hit_a = ex_writes && (ex_mem_i.rd == rs1_i);
    assign ex_hit_b = ex_writes && (ex_mem_i.rd == rs2_i);
    assign wb_hit_a = wb_writes && (wb_i.rd == rs1_i);
    assign wb_hit_b = wb_writes && (wb_i.rd == rs2_i);

    // Youngest producer has priority
    assign fwd_a_sel_o = ex_hit_a || wb_hit_a;
    assign fwd_b_sel_o = ex_hit_b || wb_hit_b;
    assign fwd_a_o     = ex_hit_a ? ex_mem_i.result : wb_i.data;
    assign fwd_b_o     = ex_hit_b ? ex_mem_i.result : wb_i.data;

endmodule

//--- rtl/fetch_stage.sv
module fetch_stage (
    input  logic               clk,
    input  logic               rst_n_i,
    input  rv32i_pkg::word_t   inst_rdata_i,
    output rv32i_pkg::word_t   inst_addr_o,
    output rv32i_pkg::if_id_t  if_id_o
);
    import rv32i_pkg::*;

    word_t    pc_q;
    word_t    rdata_pc_q;
    logic     rvalid_q;
    if_id_t   if_id_q;
    ctrl_t    dec_ctrl;
    logic     dec_valid;
    reg_idx_t dec_rs1;
    reg_idx_t dec_rs2;
    reg_idx_t dec_rd;
    word_t    dec_imm;

    assign inst_addr_o = pc_q;

    // No redirects, so the PC just walks forward
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            rdata_pc_q <= RESET_PC;
            rvalid_q   <= 1'b0;
        end else begin
            pc_q       <= pc_q + PC_STEP;
            rdata_pc_q <= pc_q;
            // Word on the bus is only meaningful one cycle after the first fetch
            rvalid_q   <= 1'b1;
        end
    end

    instr_decoder u_decoder (
        .instr_i (inst_rdata_i),
        .ctrl_o  (dec_ctrl),
        .valid_o (dec_valid),
        .rs1_o   (dec_rs1),
        .rs2_o   (dec_rs2),
        .rd_o    (dec_rd),
        .imm_o   (dec_imm)
    );

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_q <= '0;
        end else begin
            if_id_q.valid <= rvalid_q && dec_valid;
            if_id_q.pc    <= rdata_pc_q;
            if_id_q.rs1   <= dec_rs1;
            if_id_q.rs2   <= dec_rs2;
            if_id_q.rd    <= dec_rd;
            if_id_q.imm   <= dec_imm;
            if_id_q.ctrl  <= dec_ctrl;
        end
    end

    assign if_id_o = if_id_q;

endmodule

//--- rtl/instr_decoder.sv
module instr_decoder (
    input  rv32i_pkg::word_t    instr_i,
    output rv32i_pkg::ctrl_t    ctrl_o,
    output logic                valid_o,
    output rv32i_pkg::reg_idx_t rs1_o,
    output rv32i_pkg::reg_idx_t rs2_o,
    output rv32i_pkg::reg_idx_t rd_o,
    output rv32i_pkg::word_t    imm_o
);
    import rv32i_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_i_type;
    word_t      imm_s_type;
    word_t      imm_u_type;

    // funct7 bit 5 picks sub and sra; sub only exists in register form
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic f7b5,
                                           input logic is_reg);
        alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && f7b5) ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = f7b5 ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_u_type = {instr_i[31:12], 12'h000};

    always_comb begin
        ctrl_o             = '0;
        ctrl_o.alu_op      = alu_add;
        ctrl_o.store_width = store_width_e'(funct3);
        valid_o            = 1'b1;
        rs1_o              = instr_i[19:15];
        rs2_o              = instr_i[24:20];
        rd_o               = instr_i[11:7];
        imm_o              = imm_i_type;
        case (opcode)
            op_lui: begin
                ctrl_o.alu_op    = alu_pass_b;
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.reg_write = 1'b1;
                imm_o            = imm_u_type;
                rs1_o            = '0;
                rs2_o            = '0;
            end
            op_auipc: begin
                ctrl_o.a1_is_pc  = 1'b1;
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.reg_write = 1'b1;
                imm_o            = imm_u_type;
                rs1_o            = '0;
                rs2_o            = '0;
            end
            op_imm: begin
                ctrl_o.alu_op    = alu_decode(funct3, alt, 1'b0);
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.reg_write = 1'b1;
                rs2_o            = '0;
            end
            op_reg: begin
                ctrl_o.alu_op    = alu_decode(funct3, alt, 1'b1);
                ctrl_o.reg_write = 1'b1;
            end
            op_store: begin
                // Address is rs1 + S immediate, rs2 carries the data
                ctrl_o.b_is_imm  = 1'b1;
                ctrl_o.mem_write = 1'b1;
                imm_o            = imm_s_type;
                valid_o          = funct3 inside {3'b000, 3'b001, 3'b010};
            end
            default: begin
                valid_o = 1'b0;
                rs1_o   = '0;
                rs2_o   = '0;
            end
        endcase
    end

endmodule

//--- rtl/mem_wb_stage.sv
module mem_wb_stage (
    input  logic                clk,
    input  logic                rst_n_i,
    input  rv32i_pkg::ex_mem_t  ex_mem_i,
    output logic                data_write_o,
    output rv32i_pkg::word_t    data_addr_o,
    output rv32i_pkg::mbe_t     data_mbe_o,
    output rv32i_pkg::word_t    data_wdata_o,
    output rv32i_pkg::wb_t      wb_o
);
    import rv32i_pkg::*;

    wb_t wb_q;

    // Memory takes the write in the cycle it is presented
    assign data_write_o = ex_mem_i.valid && ex_mem_i.ctrl.mem_write;
    assign data_addr_o  = {ex_mem_i.result[XLEN-1:2], 2'b00};
    assign data_mbe_o   = ex_mem_i.mbe;
    // Move byte and half data into the addressed lane
    assign data_wdata_o = ex_mem_i.store_data << {ex_mem_i.result[1:0], 3'b000};

    // MEM/WB register
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q.we   <= ex_mem_i.valid && ex_mem_i.ctrl.reg_write;
            wb_q.rd   <= ex_mem_i.rd;
            wb_q.data <= ex_mem_i.result;
        end
    end

    assign wb_o = wb_q;

endmodule

//--- rtl/regfile.sv
module regfile (
    input  logic                clk,
    input  logic                rst_n_i,
    input  rv32i_pkg::reg_idx_t rs1_i,
    input  rv32i_pkg::reg_idx_t rs2_i,
    input  rv32i_pkg::wb_t      wb_i,
    output rv32i_pkg::word_t    rs1_data_o,
    output rv32i_pkg::word_t    rs2_data_o
);
    import rv32i_pkg::*;

    word_t regs_q [NUM_REGS];

    // x0 is never written
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && (wb_i.rd != '0)) begin
            regs_q[wb_i.rd] <= wb_i.data;
        end
    end

    // Same-cycle write is visible to the read, covers a producer three ahead
    function automatic word_t read_port(input reg_idx_t idx);
        word_t data;
        if (idx == '0) begin
            data = '0;
        end else if (wb_i.we && (wb_i.rd == idx)) begin
            data = wb_i.data;
        end else begin
            data = regs_q[idx];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_i);
        rs2_data_o = read_port(rs2_i);
    end

endmodule

//--- rtl/rv32i_core.sv
module rv32i_core (
    input  logic              clk,
    input  logic              rst_n_i,
    input  rv32i_pkg::word_t  inst_rdata_i,
    output rv32i_pkg::word_t  inst_addr_o,
    output logic              data_write_o,
    output rv32i_pkg::word_t  data_addr_o,
    output rv32i_pkg::mbe_t   data_mbe_o,
    output rv32i_pkg::word_t  data_wdata_o
);
    import rv32i_pkg::*;

    if_id_t   if_id;
    ex_mem_t  ex_mem;
    wb_t      wb;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    fwd_a;
    word_t    fwd_b;
    logic     fwd_a_sel;
    logic     fwd_b_sel;
    reg_idx_t id_ex_rs1;
    reg_idx_t id_ex_rs2;

    fetch_stage u_fetch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_rdata_i (inst_rdata_i),
        .inst_addr_o  (inst_addr_o),
        .if_id_o      (if_id)
    );

    // Register reads happen while the instruction sits in IF/ID
    regfile u_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_i      (if_id.rs1),
        .rs2_i      (if_id.rs2),
        .wb_i       (wb),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .if_id_i     (if_id),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .fwd_a_i     (fwd_a),
        .fwd_b_i     (fwd_b),
        .fwd_a_sel_i (fwd_a_sel),
        .fwd_b_sel_i (fwd_b_sel),
        .id_ex_rs1_o (id_ex_rs1),
        .id_ex_rs2_o (id_ex_rs2),
        .ex_mem_o    (ex_mem)
    );

    forwarding_unit u_forward (
        .rs1_i       (id_ex_rs1),
        .rs2_i       (id_ex_rs2),
        .ex_mem_i    (ex_mem),
        .wb_i        (wb),
        .fwd_a_o     (fwd_a),
        .fwd_b_o     (fwd_b),
        .fwd_a_sel_o (fwd_a_sel),
        .fwd_b_sel_o (fwd_b_sel)
    );

    mem_wb_stage u_mem_wb (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ex_mem_i     (ex_mem),
        .data_write_o (data_write_o),
        .data_addr_o  (data_addr_o),
        .data_mbe_o   (data_mbe_o),
        .data_wdata_o (data_wdata_o),
        .wb_o         (wb)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rv32i_core -f rv32i_core.f -o sim_rv32i_core

./obj_dir/sim_rv32i_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    exit 1
fi
exit 0

//--- rv32i_core.f
+incdir+verif
common/rv32i_pkg.sv
rtl/instr_decoder.sv
rtl/fetch_stage.sv
rtl/regfile.sv
execute/forwarding_unit.sv
execute/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/rv32i_core.sv
verif/tb_rv32i_core.sv

//--- verif/rv32i_model.svh
`ifndef RV32I_MODEL_SVH
`define RV32I_MODEL_SVH

// One expected store: word address, byte mask, lane-shifted data
typedef struct packed {
    word_t addr;
    mbe_t  mbe;
    word_t data;
} store_rec_t;

localparam int    PROG_LEN = 300;
localparam word_t NOP_WORD = 32'h0000_0013;

word_t      prog_mem [512];
word_t      model_regs [NUM_REGS];
store_rec_t exp_q [$];
integer     seed = 32'h92f7_9ebd;

function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
endfunction

// Small register set so that back-to-back dependences are common
function automatic reg_idx_t pick_reg();
    return reg_idx_t'(rand_below(8));
endfunction

function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// RV32I integer semantics, alt is instruction bit 30
function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic write_reg(input reg_idx_t rd, input word_t val);
    if (rd != '0) begin
        model_regs[rd] = val;
    end
endtask

task automatic build_program();
    word_t       pc;
    word_t       addr;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [1:0]  off;
    int unsigned kind;
    store_rec_t  rec;
    for (int r = 0; r < NUM_REGS; r++) begin
        model_regs[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
        pc    = word_t'(i) * PC_STEP;
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        f3    = 3'(rand_below(8));
        imm12 = 12'(rand_below(4096));
        imm20 = 20'(rand_below(1 << 20));
        kind  = rand_below(10);
        if (kind < 3) begin
            alt = (f3 == 3'd5) && (rand_below(2) == 1);
            // Shift immediates carry only shamt and the arithmetic bit
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm12 = {1'b0, alt, 5'd0, imm12[4:0]};
            end
            prog_mem[9'(i)] = {imm12, rs1, f3, rd, op_imm};
            write_reg(rd, alu_ref(f3, alt, model_regs[rs1], sext12(imm12)));
        end else if (kind < 6) begin
            alt = (f3 == 3'd0 || f3 == 3'd5) && (rand_below(2) == 1);
            prog_mem[9'(i)] = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, op_reg};
            write_reg(rd, alu_ref(f3, alt, model_regs[rs1], model_regs[rs2]));
        end else if (kind == 6) begin
            prog_mem[9'(i)] = {imm20, rd, op_lui};
            write_reg(rd, {imm20, 12'h000});
        end else if (kind == 7) begin
            prog_mem[9'(i)] = {imm20, rd, op_auipc};
            write_reg(rd, pc + {imm20, 12'h000});
        end else begin
            f3    = 3'(rand_below(3));
            imm12 = 12'(rand_below(32)) - 12'd16;
            addr  = model_regs[rs1] + sext12(imm12);
            off   = addr[1:0];
            rec.addr = {addr[31:2], 2'b00};
            case (f3)
                3'd0:    rec.mbe = mbe_t'(4'b0001 << off);
                3'd1:    rec.mbe = mbe_t'(4'b0011 << off);
                default: rec.mbe = 4'b1111;
            endcase
            rec.data = model_regs[rs2] << {off, 3'b000};
            prog_mem[9'(i)] = {imm12[11:5], rs2, rs1, f3, imm12[4:0], op_store};
            exp_q.push_back(rec);
        end
    end
endtask

`endif

//--- verif/tb_rv32i_core.sv
module tb_rv32i_core;
    import rv32i_pkg::*;

    `include "rv32i_model.svh"

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    // Fetch to data port takes four cycles
    localparam int PIPE_FILL     = 4;
    localparam int DRAIN_CYCLES  = PIPE_FILL + 4;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + PROG_LEN + 20) * CLK_PERIOD;

    logic  clk;
    logic  rst_n_i;
    word_t inst_rdata_i;
    word_t inst_addr_o;
    logic  data_write_o;
    word_t data_addr_o;
    mbe_t  data_mbe_o;
    word_t data_wdata_o;

    int    errors = 0;
    int    stores_seen = 0;
    int    total_stores = 0;
    int    cyc = 0;
    word_t exp_pc = RESET_PC;

    rv32i_core dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_rdata_i (inst_rdata_i),
        .inst_addr_o  (inst_addr_o),
        .data_write_o (data_write_o),
        .data_addr_o  (data_addr_o),
        .data_mbe_o   (data_mbe_o),
        .data_wdata_o (data_wdata_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_mbe(input string name, input mbe_t exp, input mbe_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic word_t fetch_word(input word_t addr);
        if (addr < word_t'(PROG_LEN) * PC_STEP) begin
            return prog_mem[addr[10:2]];
        end
        return NOP_WORD;
    endfunction

    // Compare one store on the data port with the oldest queued record
    task automatic check_store();
        store_rec_t rec;
        if (exp_q.size() == 0) begin
            errors++;
            $display("Extra store at address %h: the model has no store left", data_addr_o);
        end else begin
            rec = exp_q.pop_front();
            check_word($sformatf("store %0d address", stores_seen), rec.addr, data_addr_o);
            check_mbe($sformatf("store %0d mask", stores_seen), rec.mbe, data_mbe_o);
            check_word($sformatf("store %0d data", stores_seen), rec.data, data_wdata_o);
        end
        stores_seen++;
    endtask

    // Instruction memory with a one-cycle read
    always @(posedge clk) begin
        inst_rdata_i <= fetch_word(inst_addr_o);
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            exp_pc = RESET_PC;
            check_word("fetch address in reset", RESET_PC, inst_addr_o);
            if (data_write_o) begin
                errors++;
                $display("data_write_o was high during reset");
            end
        end else begin
            check_word($sformatf("fetch address cycle %0d", cyc), exp_pc, inst_addr_o);
            exp_pc = exp_pc + PC_STEP;
            if (data_write_o) begin
                if (cyc < PIPE_FILL) begin
                    errors++;
                    $display("data_write_o was high in cycle %0d after reset", cyc);
                end
                check_store();
            end
            cyc++;
        end
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units without the run finishing",
                 WATCHDOG_TIME);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        inst_rdata_i = NOP_WORD;
        build_program();
        total_stores = exp_q.size();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n_i <= 1'b1;
        // Last instruction reaches the data port PIPE_FILL cycles after its fetch
        repeat (PROG_LEN + DRAIN_CYCLES) @(posedge clk);
        @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected stores never appeared on the data port", exp_q.size());
        end
        $display("Errors: %0d, stores seen: %0d, stores expected: %0d",
                 errors, stores_seen, total_stores);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
